// File: filelist.f
+incdir+rtl
rtl/branchPredPkg.sv
rtl/predUpdateIf.sv
rtl/fetchCtrl.sv
rtl/dirCounterTable.sv
rtl/branchTargetBuffer.sv
rtl/predSnapshotFile.sv
rtl/updateQueue.sv
rtl/branchPredictor.sv
verif/branchPredictor_assertions.sv
verif/branchPredictorTb.sv

// File: rtl/branchPredPkg.sv
`default_nettype none

`include "branchPred_params.svh"

package branchPredPkg;

    // Instruction-word address
    typedef logic [`PC_WIDTH-1:0] pc_t;

    // Word offset inside a fetch block
    typedef logic [`OFFS_WIDTH-1:0] fetchOffs_t;

    // Tag of an in-flight fetch, also the snapshot index
    typedef logic [`FETCHID_WIDTH-1:0] fetchId_t;

    // Global branch history, newest outcome in bit 0
    typedef logic [`HIST_WIDTH-1:0] bhist_t;

    // Gshare counter index
    typedef logic [`DIR_IDX_WIDTH-1:0] dirIdx_t;

    // Target buffer set index
    typedef logic [`BTB_IDX_WIDTH-1:0] btbIdx_t;

    // Two-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        STATE_CLEAR,
        STATE_PREDICT,
        STATE_RECOVER
    } fetchState_t;

endpackage

`default_nettype wire

// File: rtl/branchPred_params.svh
`ifndef BRANCHPRED_PARAMS_SVH
`define BRANCHPRED_PARAMS_SVH

// Instruction-word address and fetch block geometry
`define PC_WIDTH        16
`define OFFS_WIDTH      2

// Fetch tracking and global history
`define FETCHID_WIDTH   4
`define HIST_WIDTH      8

// Predictor table sizes
`define BTB_IDX_WIDTH   4
`define DIR_IDX_WIDTH   6
`define UPDQ_DEPTH      4

// First fetch address after reset
`define ENTRY_POINT     16'h0100

`endif

// File: rtl/branchPredictor.sv
`default_nettype none

`include "branchPred_params.svh"

module branchPredictor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pcValid,
    input  branchPredPkg::fetchId_t    fetchId,
    input  logic                       misprValid,
    input  branchPredPkg::fetchId_t    misprFetchId,
    input  logic                       misprTaken,
    input  branchPredPkg::pc_t         misprTarget,
    input  logic                       updValid,
    input  branchPredPkg::fetchId_t    updFetchId,
    input  logic                       updTaken,
    input  branchPredPkg::fetchOffs_t  updOffs,
    input  branchPredPkg::pc_t         updTarget,
    output branchPredPkg::pc_t         pc,
    output logic                       stall,
    output logic                       predValid,
    output logic                       predTaken,
    output branchPredPkg::fetchOffs_t  predOffs,
    output branchPredPkg::pc_t         predTarget,
    output logic                       limitValid,
    output branchPredPkg::fetchId_t    limitFetchId
);
    import branchPredPkg::*;

    bhist_t     history;
    logic       clearBusy;
    logic       btbHit;
    fetchOffs_t btbOffs;
    pc_t        btbTarget;
    logic       ctrTaken;
    logic       snapWe;
    fetchId_t   snapRaddr;
    pc_t        snapPc;
    bhist_t     snapHistory;

    // Training path from the queue into both tables
    predUpdateIf updBus ();

    fetchCtrl fetchCtrl_i (
        .clk         (clk),
        .rst         (rst),
        .pcValid     (pcValid),
        .fetchId     (fetchId),
        .misprValid  (misprValid),
        .misprTaken  (misprTaken),
        .misprTarget (misprTarget),
        .clearBusy   (clearBusy),
        .btbHit      (btbHit),
        .btbOffs     (btbOffs),
        .btbTarget   (btbTarget),
        .ctrTaken    (ctrTaken),
        .snapHistory (snapHistory),
        .pc          (pc),
        .history     (history),
        .stall       (stall),
        .predValid   (predValid),
        .predTaken   (predTaken),
        .predOffs    (predOffs),
        .predTarget  (predTarget),
        .snapWe      (snapWe)
    );

    dirCounterTable dirCounterTable_i (
        .clk           (clk),
        .rst           (rst),
        .lookupPc      (pc),
        .lookupHistory (history),
        .upd           (updBus.sink),
        .taken         (ctrTaken),
        .clearBusy     (clearBusy)
    );

    branchTargetBuffer branchTargetBuffer_i (
        .clk      (clk),
        .rst      (rst),
        .lookupPc (pc),
        .upd      (updBus.sink),
        .hit      (btbHit),
        .offs     (btbOffs),
        .target   (btbTarget)
    );

    predSnapshotFile predSnapshotFile_i (
        .clk      (clk),
        .we       (snapWe),
        .waddr    (fetchId),
        .wPc      (pc),
        .wHistory (history),
        .raddr    (snapRaddr),
        .rPc      (snapPc),
        .rHistory (snapHistory)
    );

    updateQueue updateQueue_i (
        .clk          (clk),
        .rst          (rst),
        .updValid     (updValid),
        .updFetchId   (updFetchId),
        .updTaken     (updTaken),
        .updOffs      (updOffs),
        .updTarget    (updTarget),
        .misprValid   (misprValid),
        .misprFetchId (misprFetchId),
        .snapPc       (snapPc),
        .snapHistory  (snapHistory),
        .snapRaddr    (snapRaddr),
        .limitValid   (limitValid),
        .limitFetchId (limitFetchId),
        .upd          (updBus.source)
    );

endmodule

`default_nettype wire

// File: rtl/branchTargetBuffer.sv
`default_nettype none

`include "branchPred_params.svh"

module branchTargetBuffer (
    input  logic                       clk,
    input  logic                       rst,
    input  branchPredPkg::pc_t         lookupPc,
    predUpdateIf.sink                  upd,
    output logic                       hit,
    output branchPredPkg::fetchOffs_t  offs,
    output branchPredPkg::pc_t         target
);
    import branchPredPkg::*;

    localparam int TAG_WIDTH = `PC_WIDTH - `OFFS_WIDTH - `BTB_IDX_WIDTH;
    localparam int DEPTH     = 1 << `BTB_IDX_WIDTH;

    logic [DEPTH-1:0]     validBits;
    logic [TAG_WIDTH-1:0] tagMem [DEPTH];
    fetchOffs_t           offsMem [DEPTH];
    pc_t                  targetMem [DEPTH];

    btbIdx_t              lookupIdx;
    btbIdx_t              updIdx;
    logic [TAG_WIDTH-1:0] lookupTag;
    logic [TAG_WIDTH-1:0] updTag;
    fetchOffs_t           lookupOffs;
    logic                 updWe;

    // PC splits into tag, block index and word offset
    assign lookupOffs = lookupPc[`OFFS_WIDTH-1:0];
    assign lookupIdx  = lookupPc[`OFFS_WIDTH +: `BTB_IDX_WIDTH];
    assign lookupTag  = lookupPc[`PC_WIDTH-1 -: TAG_WIDTH];
    assign updIdx     = upd.pc[`OFFS_WIDTH +: `BTB_IDX_WIDTH];
    assign updTag     = upd.pc[`PC_WIDTH-1 -: TAG_WIDTH];

    // Only taken branches allocate
    assign updWe = upd.valid && upd.taken;

    // The branch must sit at or after the word where fetch enters the block
    assign hit    = validBits[lookupIdx]
                    && (tagMem[lookupIdx] == lookupTag)
                    && (offsMem[lookupIdx] >= lookupOffs);
    assign offs   = offsMem[lookupIdx];
    assign target = targetMem[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (updWe) begin
            validBits[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updWe) begin
            tagMem[updIdx]    <= updTag;
            offsMem[updIdx]   <= upd.offs;
            targetMem[updIdx] <= upd.target;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dirCounterTable.sv
`default_nettype none

`include "branchPred_params.svh"

module dirCounterTable (
    input  logic                   clk,
    input  logic                   rst,
    input  branchPredPkg::pc_t     lookupPc,
    input  branchPredPkg::bhist_t  lookupHistory,
    predUpdateIf.sink              upd,
    output logic                   taken,
    output logic                   clearBusy
);
    import branchPredPkg::*;

    localparam int DEPTH = 1 << `DIR_IDX_WIDTH;

    ctr_t    ctrMem [DEPTH];
    dirIdx_t lookupIdx;
    dirIdx_t updIdx;
    dirIdx_t sweepIdx;
    ctr_t    updCtr;
    ctr_t    nextCtr;

    // Gshare index, block bits of the PC folded with the history
    assign lookupIdx = lookupPc[`OFFS_WIDTH +: `DIR_IDX_WIDTH]
                       ^ lookupHistory[`DIR_IDX_WIDTH-1:0];
    assign updIdx    = upd.pc[`OFFS_WIDTH +: `DIR_IDX_WIDTH]
                       ^ upd.history[`DIR_IDX_WIDTH-1:0];

    assign taken = ctrMem[lookupIdx][1];

    // Step toward the outcome and hold at the ends
    always_comb begin
        updCtr  = ctrMem[updIdx];
        nextCtr = updCtr;
        if (upd.taken && updCtr != 2'd3) begin
            nextCtr = updCtr + 2'd1;
        end else if (!upd.taken && updCtr != 2'd0) begin
            nextCtr = updCtr - 2'd1;
        end
    end

    // Sweep one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx  <= '0;
            clearBusy <= 1'b1;
        end else if (clearBusy) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == '1) begin
                clearBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearBusy) begin
            ctrMem[sweepIdx] <= 2'd1;   // weakly not taken
        end else if (upd.valid) begin
            ctrMem[updIdx] <= nextCtr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetchCtrl.sv
`default_nettype none

`include "branchPred_params.svh"

module fetchCtrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pcValid,
    input  branchPredPkg::fetchId_t    fetchId,
    input  logic                       misprValid,
    input  logic                       misprTaken,
    input  branchPredPkg::pc_t         misprTarget,
    input  logic                       clearBusy,
    input  logic                       btbHit,
    input  branchPredPkg::fetchOffs_t  btbOffs,
    input  branchPredPkg::pc_t         btbTarget,
    input  logic                       ctrTaken,
    input  branchPredPkg::bhist_t      snapHistory,
    output branchPredPkg::pc_t         pc,
    output branchPredPkg::bhist_t      history,
    output logic                       stall,
    output logic                       predValid,
    output logic                       predTaken,
    output branchPredPkg::fetchOffs_t  predOffs,
    output branchPredPkg::pc_t         predTarget,
    output logic                       snapWe
);
    import branchPredPkg::*;

    fetchState_t state;
    fetchState_t stateNext;
    logic        accept;
    logic        takeTarget;
    pc_t         nextBlockPc;

    // Fetch is held off only while the counter sweep runs
    assign stall = (state == STATE_CLEAR) && clearBusy;

    // A mispredict squashes the fetch of its own cycle
    assign accept = pcValid && !stall && !misprValid;

    // No prediction in the cycle right after a redirect
    assign predValid  = btbHit && !stall && (state != STATE_RECOVER);
    assign predTaken  = ctrTaken;
    assign predOffs   = btbOffs;
    assign predTarget = btbTarget;
    assign takeTarget = predValid && predTaken;

    assign nextBlockPc = {pc[`PC_WIDTH-1:`OFFS_WIDTH] + 1'b1, {`OFFS_WIDTH{1'b0}}};

    always_comb begin
        if (state == STATE_CLEAR && clearBusy) begin
            stateNext = STATE_CLEAR;
        end else if (misprValid) begin
            stateNext = STATE_RECOVER;
        end else begin
            stateNext = STATE_PREDICT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= STATE_CLEAR;
            pc      <= `ENTRY_POINT;
            history <= '0;
        end else begin
            state <= stateNext;
            if (misprValid) begin
                // Restart from the snapshot history plus the resolved outcome
                pc      <= misprTarget;
                history <= {snapHistory[$bits(bhist_t)-2:0], misprTaken};
            end else if (accept) begin
                pc <= takeTarget ? predTarget : nextBlockPc;
                if (predValid) begin
                    history <= {history[$bits(bhist_t)-2:0], predTaken};
                end
            end
        end
    end

    // Every accepted fetch records its snapshot
    assign snapWe = accept;

endmodule

`default_nettype wire

// File: rtl/predSnapshotFile.sv
`default_nettype none

`include "branchPred_params.svh"

module predSnapshotFile (
    input  logic                     clk,
    input  logic                     we,
    input  branchPredPkg::fetchId_t  waddr,
    input  branchPredPkg::pc_t       wPc,
    input  branchPredPkg::bhist_t    wHistory,
    input  branchPredPkg::fetchId_t  raddr,
    output branchPredPkg::pc_t       rPc,
    output branchPredPkg::bhist_t    rHistory
);
    import branchPredPkg::*;

    localparam int DEPTH = 1 << `FETCHID_WIDTH;

    // One entry per fetch ID in flight
    pc_t    pcMem [DEPTH];
    bhist_t histMem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            pcMem[waddr]   <= wPc;
            histMem[waddr] <= wHistory;
        end
    end

    // Shared read port for recovery and training
    assign rPc      = pcMem[raddr];
    assign rHistory = histMem[raddr];

endmodule

`default_nettype wire

// File: rtl/predUpdateIf.sv
`default_nettype none

// One training write, shared by the target buffer and the counter table
interface predUpdateIf;
    import branchPredPkg::*;

    logic       valid;
    pc_t        pc;
    bhist_t     history;
    fetchOffs_t offs;
    logic       taken;
    pc_t        target;

    modport source (output valid, pc, history, offs, taken, target);

    modport sink (input valid, pc, history, offs, taken, target);

endinterface

`default_nettype wire

// File: rtl/updateQueue.sv
`default_nettype none

`include "branchPred_params.svh"

module updateQueue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       updValid,
    input  branchPredPkg::fetchId_t    updFetchId,
    input  logic                       updTaken,
    input  branchPredPkg::fetchOffs_t  updOffs,
    input  branchPredPkg::pc_t         updTarget,
    input  logic                       misprValid,
    input  branchPredPkg::fetchId_t    misprFetchId,
    input  branchPredPkg::pc_t         snapPc,
    input  branchPredPkg::bhist_t      snapHistory,
    output branchPredPkg::fetchId_t    snapRaddr,
    output logic                       limitValid,
    output branchPredPkg::fetchId_t    limitFetchId,
    predUpdateIf.source                upd
);
    import branchPredPkg::*;

    localparam int DEPTH     = `UPDQ_DEPTH;
    localparam int PTR_WIDTH = $clog2(DEPTH);

    fetchId_t   idMem [DEPTH];
    logic       takenMem [DEPTH];
    fetchOffs_t offsMem [DEPTH];
    pc_t        targetMem [DEPTH];

    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [PTR_WIDTH:0]   count;
    logic                 headValid;
    logic                 deq;

    assign headValid = (count != '0);

    // Mispredict owns the snapshot read port this cycle
    assign deq       = headValid && !misprValid;
    assign snapRaddr = misprValid ? misprFetchId : idMem[head];

    // Oldest fetch ID whose snapshot is still needed
    assign limitValid   = headValid || updValid;
    assign limitFetchId = headValid ? idMem[head] : updFetchId;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (updValid) begin
                tail <= tail + 1'b1;
            end
            if (deq) begin
                head <= head + 1'b1;
            end
            case ({updValid, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            idMem[tail]     <= updFetchId;
            takenMem[tail]  <= updTaken;
            offsMem[tail]   <= updOffs;
            targetMem[tail] <= updTarget;
        end
    end

    // Training write goes out the clock after the dequeue
    always_ff @(posedge clk) begin
        if (rst) begin
            upd.valid <= 1'b0;
        end else begin
            upd.valid <= deq;
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            upd.pc      <= snapPc;
            upd.history <= snapHistory;
            upd.offs    <= offsMem[head];
            upd.taken   <= takenMem[head];
            upd.target  <= targetMem[head];
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module branchPredictorTb \
    -f filelist.f \
    && ./obj_dir/VbranchPredictorTb > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: verif/branchPredictorTb.sv
`default_nettype none

`include "branchPred_params.svh"

module branchPredictorTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        string       name;
        logic        pcV;
        logic [3:0]  fid;
        logic        mV;
        logic [3:0]  mFid;
        logic        mT;
        logic [15:0] mTgt;
        logic        uV;
        logic [3:0]  uFid;
        logic        uT;
        logic [1:0]  uOffs;
        logic [15:0] uTgt;
        logic [2:0]  mask;    // bit0 pc and stall, bit1 prediction, bit2 limit
    } row_t;

    logic        clk;
    logic        rst;
    logic        pcValid;
    logic [3:0]  fetchId;
    logic        misprValid;
    logic [3:0]  misprFetchId;
    logic        misprTaken;
    logic [15:0] misprTarget;
    logic        updValid;
    logic [3:0]  updFetchId;
    logic        updTaken;
    logic [1:0]  updOffs;
    logic [15:0] updTarget;
    logic [15:0] pc;
    logic        stall;
    logic        predValid;
    logic        predTaken;
    logic [1:0]  predOffs;
    logic [15:0] predTarget;
    logic        limitValid;
    logic [3:0]  limitFetchId;

    row_t        rows[$];
    int          cycleCount;
    int          timeoutLimit;
    int          errCount;
    int          testErrs;
    int          testsPassed;
    int          testsFailed;
    logic [31:0] seed;

    // Reference model state
    logic [15:0] mPc;
    logic [7:0]  mHist;
    logic        mRecover;
    logic [1:0]  mCtr [64];
    logic        mBv [16];
    logic [9:0]  mTag [16];
    logic [1:0]  mBOffs [16];
    logic [15:0] mBTgt [16];
    logic [15:0] mSnapPc [16];
    logic [7:0]  mSnapHist [16];
    logic [3:0]  qId [4];
    logic        qT [4];
    logic [1:0]  qOffs [4];
    logic [15:0] qTgt [4];
    int          qHead;
    int          qTail;
    int          qCount;
    logic        pendV;
    logic [15:0] pendPc;
    logic [7:0]  pendHist;
    logic        pendT;
    logic [1:0]  pendOffs;
    logic [15:0] pendTgt;
    logic        eValid;
    logic        eTaken;
    logic [1:0]  eOffs;
    logic [15:0] eTgt;
    logic        eLimV;
    logic [3:0]  eLimId;

    branchPredictor branchPredictor_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic addRow(input string name, input logic pcV, input logic [3:0] fid,
                          input logic mV, input logic [3:0] mFid, input logic mT,
                          input logic [15:0] mTgt, input logic uV, input logic [3:0] uFid,
                          input logic uT, input logic [1:0] uOffs, input logic [15:0] uTgt);
        row_t r;
        r = '{name, pcV, fid, mV, mFid, mT, mTgt, uV, uFid, uT, uOffs, uTgt, 3'b111};
        rows.push_back(r);
    endtask

    task automatic addFetch(input string name, input logic [3:0] fid);
        addRow(name, 1, fid, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic addIdle(input string name);
        addRow(name, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic addMispr(input string name, input logic [3:0] fid, input logic t,
                            input logic [15:0] tgt);
        addRow(name, 0, 0, 1, fid, t, tgt, 0, 0, 0, 0, 0);
    endtask

    task automatic addUpd(input string name, input logic [3:0] fid, input logic t,
                          input logic [1:0] offs, input logic [15:0] tgt);
        addRow(name, 0, 0, 0, 0, 0, 0, 1, fid, t, offs, tgt);
    endtask

    task automatic checkVal(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s expected %h actual %h", name, what, exp, act);
            errCount++;
            testErrs++;
        end
    endtask

    // Expected outputs of this cycle from the model state
    task automatic computeExpected(input row_t r);
        logic [3:0] idx;
        logic [5:0] gi;
        idx    = mPc[5:2];
        gi     = mPc[7:2] ^ mHist[5:0];
        eValid = mBv[idx] && (mTag[idx] == mPc[15:6]) && (mBOffs[idx] >= mPc[1:0])
                 && !mRecover;
        eTaken = mCtr[gi][1];
        eOffs  = mBOffs[idx];
        eTgt   = mBTgt[idx];
        eLimV  = (qCount > 0) || r.uV;
        eLimId = (qCount > 0) ? qId[qHead] : r.uFid;
    endtask

    // Advance the model across one rising edge
    task automatic stepModel(input row_t r);
        logic [15:0] curPc;
        logic [7:0]  curHist;
        logic [5:0]  gi;
        logic [3:0]  bi;
        logic        deqV;
        curPc   = mPc;
        curHist = mHist;
        if (pendV) begin
            gi = pendPc[7:2] ^ pendHist[5:0];
            if (pendT && mCtr[gi] != 2'd3) begin
                mCtr[gi] = mCtr[gi] + 2'd1;
            end else if (!pendT && mCtr[gi] != 2'd0) begin
                mCtr[gi] = mCtr[gi] - 2'd1;
            end
            if (pendT) begin
                bi         = pendPc[5:2];
                mBv[bi]    = 1'b1;
                mTag[bi]   = pendPc[15:6];
                mBOffs[bi] = pendOffs;
                mBTgt[bi]  = pendTgt;
            end
        end
        deqV  = (qCount > 0) && !r.mV;
        pendV = deqV;
        if (deqV) begin
            pendPc   = mSnapPc[qId[qHead]];
            pendHist = mSnapHist[qId[qHead]];
            pendT    = qT[qHead];
            pendOffs = qOffs[qHead];
            pendTgt  = qTgt[qHead];
            qHead    = (qHead + 1) % 4;
            qCount--;
        end
        if (r.uV) begin
            qId[qTail]   = r.uFid;
            qT[qTail]    = r.uT;
            qOffs[qTail] = r.uOffs;
            qTgt[qTail]  = r.uTgt;
            qTail        = (qTail + 1) % 4;
            qCount++;
        end
        if (r.mV) begin
            mPc   = r.mTgt;
            mHist = {mSnapHist[r.mFid][6:0], r.mT};
        end else if (r.pcV) begin
            mPc = (eValid && eTaken) ? eTgt : {curPc[15:2] + 14'd1, 2'b00};
            if (eValid) begin
                mHist = {curHist[6:0], eTaken};
            end
        end
        if (r.pcV && !r.mV) begin
            mSnapPc[r.fid]   = curPc;
            mSnapHist[r.fid] = curHist;
        end
        mRecover = r.mV;
    endtask

    task automatic finishTest(input string name);
        if (testErrs == 0) begin
            $display("test %s: ok", name);
            testsPassed++;
        end else begin
            $display("test %s: failed with %0d errors", name, testErrs);
            testsFailed++;
        end
        testErrs = 0;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout after %0d cycles, DUT did not finish the tests", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int    stallCycles;
        string prevName;
        row_t  r;
        logic [15:0] fill;
        rst = 1'b1;
        pcValid = 0;
        fetchId = 0;
        misprValid = 0;
        misprFetchId = 0;
        misprTaken = 0;
        misprTarget = 0;
        updValid = 0;
        updFetchId = 0;
        updTaken = 0;
        updOffs = 0;
        updTarget = 0;
        cycleCount = 0;
        errCount = 0;
        testErrs = 0;
        testsPassed = 0;
        testsFailed = 0;
        seed = 32'h7b2b501c;
        timeoutLimit = 100000;

        // Stimulus table
        for (int i = 0; i < 4; i++) addFetch("seqFetch", i);
        addMispr("trainTaken", 3, 1, 16'h0200);
        addFetch("trainTaken", 4);
        addUpd("trainTaken", 4, 1, 2'd2, 16'h0340);
        repeat (3) addIdle("trainTaken");
        addMispr("trainTaken", 3, 1, 16'h0200);
        addIdle("trainTaken");
        addFetch("trainTaken", 5);
        addFetch("trainTaken", 6);
        addMispr("offsetMiss", 3, 1, 16'h0203);
        addIdle("offsetMiss");
        addFetch("offsetMiss", 7);
        addUpd("notTaken", 5, 0, 2'd2, 16'h0340);
        addUpd("notTaken", 5, 0, 2'd2, 16'h0340);
        repeat (3) addIdle("notTaken");
        addMispr("notTaken", 3, 1, 16'h0200);
        addIdle("notTaken");
        addFetch("notTaken", 8);
        seed = xorshift(seed);
        fill = seed[15:0] & 16'hfffc;
        addMispr("mispredict", 4, 0, fill);
        addFetch("mispredict", 9);
        addFetch("mispredict", 10);
        addRow("limitDrain", 0, 0, 1, 4, 1, 16'h0200, 1, 9, 1, 2'd1, 16'h0480);
        addRow("limitDrain", 0, 0, 1, 4, 1, 16'h0200, 1, 10, 0, 2'd0, 16'h0000);
        seed = xorshift(seed);
        addUpd("limitDrain", 6, 1, 2'd3, seed[15:0]);
        repeat (5) addIdle("limitDrain");
        timeoutLimit = rows.size() * 4 + 64 + 10 + 50;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        checkVal("reset", "pc", `ENTRY_POINT, pc);
        stallCycles = 0;
        while (stall) begin
            checkVal("reset", "predValid", 0, predValid);
            checkVal("reset", "limitValid", 0, limitValid);
            stallCycles++;
            @(negedge clk);
            #5;
        end
        checkVal("reset", "stallCycles", 64, stallCycles);
        checkVal("reset", "pc", `ENTRY_POINT, pc);
        finishTest("reset");

        mPc = `ENTRY_POINT;
        mHist = 0;
        mRecover = 0;
        pendV = 0;
        qHead = 0;
        qTail = 0;
        qCount = 0;
        for (int i = 0; i < 64; i++) mCtr[i] = 2'd1;
        for (int i = 0; i < 16; i++) mBv[i] = 1'b0;

        prevName = "";
        foreach (rows[i]) begin
            r = rows[i];
            if (prevName != "" && prevName != r.name) finishTest(prevName);
            prevName = r.name;
            @(negedge clk);
            pcValid = r.pcV;
            fetchId = r.fid;
            misprValid = r.mV;
            misprFetchId = r.mFid;
            misprTaken = r.mT;
            misprTarget = r.mTgt;
            updValid = r.uV;
            updFetchId = r.uFid;
            updTaken = r.uT;
            updOffs = r.uOffs;
            updTarget = r.uTgt;
            #5;
            computeExpected(r);
            if (r.mask[0]) begin
                checkVal(r.name, "pc", mPc, pc);
                checkVal(r.name, "stall", 0, stall);
            end
            if (r.mask[1]) begin
                checkVal(r.name, "predValid", eValid, predValid);
                if (eValid) begin
                    checkVal(r.name, "predTaken", eTaken, predTaken);
                    checkVal(r.name, "predOffs", eOffs, predOffs);
                    checkVal(r.name, "predTarget", eTgt, predTarget);
                end
            end
            if (r.mask[2]) begin
                checkVal(r.name, "limitValid", eLimV, limitValid);
                if (eLimV) checkVal(r.name, "limitFetchId", eLimId, limitFetchId);
            end
            stepModel(r);
        end
        finishTest(prevName);

        $display("Tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed,
                 errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/branchPredictor_assertions.sv
`default_nettype none

`include "branchPred_params.svh"

// Bound into both the update queue and the fetch controller.
// Ports that do not exist in a bind target are tied to quiet values there.
module branchPredictor_assertions (
    input logic       clk,
    input logic       rst,
    input logic       updValid,
    input logic [2:0] count,
    input logic       stall,
    input logic       predValid,
    input logic       misprValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // The update source must respect the fetch limit and never overrun the queue
    queueNoOverrun: assert property (@(posedge clk) disable iff (rst)
        (count == `UPDQ_DEPTH) |-> !updValid)
        else $error("update arrived while the queue was full");

    // No prediction while the counter sweep holds fetch
    noPredInStall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !predValid)
        else $error("prediction raised during stall");

    // Redirect cycle carries no prediction
    noPredAfterMispr: assert property (@(posedge clk) disable iff (rst)
        misprValid |=> !predValid)
        else $error("prediction raised in the cycle after a mispredict");

endmodule

bind updateQueue branchPredictor_assertions updQueueChecks (
    .clk        (clk),
    .rst        (rst),
    .updValid   (updValid),
    .count      (count),
    .stall      (1'b0),
    .predValid  (1'b0),
    .misprValid (1'b0)
);

bind fetchCtrl branchPredictor_assertions fetchCtrlChecks (
    .clk        (clk),
    .rst        (rst),
    .updValid   (1'b0),
    .count      (3'd0),
    .stall      (stall),
    .predValid  (predValid),
    .misprValid (misprValid)
);

`default_nettype wire
